// File: include/glb_config.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// chain sizing; tile count must stay even, address = tile sel + word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef GLB_CONFIG_SVH
`define GLB_CONFIG_SVH

// tiles in the chain, even only
`define GLB_NUM_TILES 4

// word address inside one bank, 16 words
`define GLB_BANK_ADDR_WIDTH 4

// tile select bits, upper part of the address
`define GLB_TILE_SEL_WIDTH 2

// full address seen on the processor port
`define GLB_ADDR_WIDTH (`GLB_TILE_SEL_WIDTH + `GLB_BANK_ADDR_WIDTH)

// data word
`define GLB_DATA_WIDTH 32

`endif

// File: rtl/glb_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet layout for the chain; fields valid only with their enable bit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "glb_config.svh"

package glb_pkg;

    // write request, 39 bits
    typedef struct packed {
        logic                       wr_en;
        logic [`GLB_ADDR_WIDTH-1:0] wr_addr;
        logic [`GLB_DATA_WIDTH-1:0] wr_data;
    } wr_packet_t;

    // read request, 7 bits
    // tile select sits in the top address bits
    typedef struct packed {
        logic                       rd_en;
        logic [`GLB_ADDR_WIDTH-1:0] rd_addr;
    } rdrq_packet_t;

    // read response, 33 bits
    typedef struct packed {
        logic                       rd_data_valid;
        logic [`GLB_DATA_WIDTH-1:0] rd_data;
    } rdrs_packet_t;

    // one stream beat between tiles, 79 bits
    // all three fields move together on every enabled edge
    typedef struct packed {
        wr_packet_t   wr;
        rdrq_packet_t rdrq;
        rdrs_packet_t rdrs;
    } packet_t;

endpackage

`default_nettype wire

// File: rtl/glb_proc_router.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// even tiles register eastbound, odd tiles westbound; no back-pressure
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module glb_proc_router
    import glb_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  wire logic   clk,
    input  wire logic   clk_en,
    input  wire logic   reset,

    // chain side
    input  packet_t      packet_w2e_wsti,
    output packet_t      packet_e2w_wsto,
    input  packet_t      packet_e2w_esti,
    output packet_t      packet_w2e_esto,

    // bank side
    output wr_packet_t   wr_packet,
    output rdrq_packet_t rdrq_packet,
    input  rdrs_packet_t rdrs_packet
);

    // parity picks the owned direction
    localparam bit IS_EVEN = ((TILE_ID % 2) == 0);

    // stream entering the register stage
    packet_t      packet_reg_in;
    // stream passing straight through
    packet_t      packet_pass;
    // register stage of the owned direction
    packet_t      packet_q;
    // registered stream after response insertion
    packet_t      packet_reg_out;
    // registered bank response
    rdrs_packet_t rdrs_q;

    // even: eastbound owned, westbound passes
    // odd: the other way round
    assign packet_reg_in = IS_EVEN ? packet_w2e_wsti : packet_e2w_esti;
    assign packet_pass   = IS_EVEN ? packet_e2w_esti : packet_w2e_wsti;

    // the only pipeline stage in this tile
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            packet_q <= '0;
        end else if (clk_en) begin
            packet_q <= packet_reg_in;
        end
    end

    // bank response, one more enabled edge before insertion
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdrs_q <= '0;
        end else if (clk_en) begin
            rdrs_q <= rdrs_packet;
        end
    end

    // insert own response into the registered stream
    // fixed latency keeps this slot empty whenever rdrs_q is valid
    always_comb begin
        packet_reg_out = packet_q;
        if (rdrs_q.rd_data_valid) begin
            packet_reg_out.rdrs = rdrs_q;
        end
    end

    // outputs per direction
    assign packet_w2e_esto = IS_EVEN ? packet_reg_out : packet_pass;
    assign packet_e2w_wsto = IS_EVEN ? packet_pass : packet_reg_out;

    // bank tap from the registered stream only
    // so each request hits this bank once around the loop
    assign wr_packet   = packet_reg_out.wr;
    assign rdrq_packet = packet_reg_out.rdrq;

endmodule

`default_nettype wire

// File: rtl/glb_bank.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16-word bank; same-edge read and write to one word gives old data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "glb_config.svh"

module glb_bank
    import glb_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  wire logic    clk,
    input  wire logic    clk_en,
    input  wire logic    reset,
    input  wr_packet_t   wr_packet,
    input  rdrq_packet_t rdrq_packet,
    output rdrs_packet_t rdrs_packet
);

    localparam int NUM_WORDS = 2 ** `GLB_BANK_ADDR_WIDTH;
    localparam int SEL_LSB   = `GLB_BANK_ADDR_WIDTH;
    localparam int SEL_MSB   = `GLB_ADDR_WIDTH - 1;

    // this tile's select value
    localparam logic [`GLB_TILE_SEL_WIDTH-1:0] MY_SEL =
        (`GLB_TILE_SEL_WIDTH)'(TILE_ID);

    logic [`GLB_DATA_WIDTH-1:0]      mem [NUM_WORDS];
    logic                            wr_hit;
    logic                            rd_hit;
    logic [`GLB_BANK_ADDR_WIDTH-1:0] wr_word;
    logic [`GLB_BANK_ADDR_WIDTH-1:0] rd_word;

    // address decode
    // upper bits pick the tile, lower bits the word
    assign wr_hit  = wr_packet.wr_en
                     && (wr_packet.wr_addr[SEL_MSB:SEL_LSB] == MY_SEL);
    assign rd_hit  = rdrq_packet.rd_en
                     && (rdrq_packet.rd_addr[SEL_MSB:SEL_LSB] == MY_SEL);
    assign wr_word = wr_packet.wr_addr[`GLB_BANK_ADDR_WIDTH-1:0];
    assign rd_word = rdrq_packet.rd_addr[`GLB_BANK_ADDR_WIDTH-1:0];

    // storage, cleared on reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (clk_en && wr_hit) begin
            mem[wr_word] <= wr_packet.wr_data;
        end
    end

    // read port, one enabled edge of latency
    // valid lasts one enabled cycle per hit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdrs_packet <= '0;
        end else if (clk_en) begin
            rdrs_packet.rd_data_valid <= rd_hit;
            if (rd_hit) begin
                rdrs_packet.rd_data <= mem[rd_word];
            end else begin
                // keep idle beats clean on the stream
                rdrs_packet.rd_data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/glb_tile.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one tile of the chain, router plus bank
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module glb_tile
    import glb_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  wire logic clk,
    input  wire logic clk_en,
    input  wire logic reset,
    input  packet_t   packet_w2e_wsti,
    output packet_t   packet_e2w_wsto,
    input  packet_t   packet_e2w_esti,
    output packet_t   packet_w2e_esto
);

    // router to bank and back
    wr_packet_t   wr_packet;
    rdrq_packet_t rdrq_packet;
    rdrs_packet_t rdrs_packet;

    glb_proc_router #(
        .TILE_ID (TILE_ID)
    ) u_router (
        .clk             (clk),
        .clk_en          (clk_en),
        .reset           (reset),
        .packet_w2e_wsti (packet_w2e_wsti),
        .packet_e2w_wsto (packet_e2w_wsto),
        .packet_e2w_esti (packet_e2w_esti),
        .packet_w2e_esto (packet_w2e_esto),
        .wr_packet       (wr_packet),
        .rdrq_packet     (rdrq_packet),
        .rdrs_packet     (rdrs_packet)
    );

    glb_bank #(
        .TILE_ID (TILE_ID)
    ) u_bank (
        .clk         (clk),
        .clk_en      (clk_en),
        .reset       (reset),
        .wr_packet   (wr_packet),
        .rdrq_packet (rdrq_packet),
        .rdrs_packet (rdrs_packet)
    );

endmodule

`default_nettype wire

// File: rtl/glb_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read latency is GLB_NUM_TILES+2 enabled edges for every tile
// clk_en is the only stall; there is no per-request handshake
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "glb_config.svh"

module glb_top
    import glb_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    clk_en,
    input  wire logic    reset,
    input  wr_packet_t   proc_wr,
    input  rdrq_packet_t proc_rdrq,
    output rdrs_packet_t proc_rdrs
);

    localparam int NUM_TILES = `GLB_NUM_TILES;

    // link k sits west of tile k; link NUM_TILES is the east end
    packet_t w2e [NUM_TILES+1];
    packet_t e2w [NUM_TILES+1];

    // processor enters at the west end, no response yet
    assign w2e[0].wr   = proc_wr;
    assign w2e[0].rdrq = proc_rdrq;
    assign w2e[0].rdrs = '0;

    // eastbound turns around into westbound
    assign e2w[NUM_TILES] = w2e[NUM_TILES];

    // only the response leaves at the west end
    // requests have been seen by every bank by then
    assign proc_rdrs = e2w[0].rdrs;

    genvar i;
    generate
        for (i = 0; i < NUM_TILES; i++) begin : g_tile
            glb_tile #(
                .TILE_ID (i)
            ) u_tile (
                .clk             (clk),
                .clk_en          (clk_en),
                .reset           (reset),
                .packet_w2e_wsti (w2e[i]),
                .packet_e2w_wsto (e2w[i]),
                .packet_e2w_esti (e2w[i+1]),
                .packet_w2e_esto (w2e[i+1])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: sim/glb_props.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound into every router; sees its register stage and response reg
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module glb_props
    import glb_pkg::*;
(
    input wire logic         clk,
    input wire logic         clk_en,
    input wire logic         reset,
    input wire packet_t      packet_q,
    input wire rdrs_packet_t rdrs_q,
    input wire packet_t      packet_w2e_esto,
    input wire packet_t      packet_e2w_wsto
);

    // own response and a passing one in one slot would lose data
    a_no_collision: assert property (
        @(posedge clk) disable iff (reset)
        !(rdrs_q.rd_data_valid && packet_q.rdrs.rd_data_valid)
    ) else $error("bank response collides with a passing response");

    // a stalled edge changes nothing downstream
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        !clk_en |=> ($stable(packet_w2e_esto) && $stable(packet_e2w_wsto))
    ) else $error("router output moved across a stalled edge");

    // first cycle out of reset, chain is empty
    a_zero_after_reset: assert property (
        @(posedge clk)
        $fell(reset) |-> (packet_w2e_esto == '0 && packet_e2w_wsto == '0)
    ) else $error("router output not zero after reset");

endmodule

bind glb_proc_router glb_props u_props (
    .clk             (clk),
    .clk_en          (clk_en),
    .reset           (reset),
    .packet_q        (packet_q),
    .rdrs_q          (rdrs_q),
    .packet_w2e_esto (packet_w2e_esto),
    .packet_e2w_wsto (packet_e2w_wsto)
);

`default_nettype wire

// File: sim/glb_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random traffic from seed 57013 against a flat memory model
// a read and a write in the same beat see the old word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "glb_config.svh"

module glb_tb
    import glb_pkg::*;
();

    localparam int NUM_TILES = `GLB_NUM_TILES;
    localparam int AW        = `GLB_ADDR_WIDTH;
    localparam int BW        = `GLB_BANK_ADDR_WIDTH;
    localparam int DW        = `GLB_DATA_WIDTH;
    localparam int NUM_ADDRS = 2 ** AW;
    // N/2 east regs, N/2 west regs, bank, response reg
    localparam int LATENCY   = NUM_TILES + 2;

    // phase lengths in driven cycles
    localparam int IDLE_CYCLES  = 10;
    localparam int NUM_PAIRS    = 32;
    localparam int MIX_CYCLES   = 200;
    localparam int STALL_CYCLES = 200;
    localparam int NUM_OPS      = IDLE_CYCLES + NUM_ADDRS + 2 * NUM_PAIRS
                                  + MIX_CYCLES + STALL_CYCLES;
    localparam longint WATCHDOG_NS = longint'(NUM_OPS + 4 * NUM_TILES + 100) * 10 * 4;

    logic         clk;
    logic         clk_en;
    logic         reset;
    wr_packet_t   proc_wr;
    rdrq_packet_t proc_rdrq;
    rdrs_packet_t proc_rdrs;

    // reference memory over the full address space
    logic [DW-1:0] ref_mem [NUM_ADDRS];
    // expected data and enabled-edge age per outstanding read
    logic [DW-1:0] exp_q [$];
    int            age_q [$];
    // enable driven for the edge now pending
    logic          last_en;
    rdrs_packet_t  last_rdrs;
    logic [AW-1:0] wr_addrs [$];
    logic [AW-1:0] last_waddr;

    int data_errors;
    int latency_errors;
    int order_errors;
    int stall_errors;

    glb_top dut (
        .clk       (clk),
        .clk_en    (clk_en),
        .reset     (reset),
        .proc_wr   (proc_wr),
        .proc_rdrq (proc_rdrq),
        .proc_rdrs (proc_rdrs)
    );

    always #5 clk = ~clk;

    // sample the response port at the falling edge, before new drive
    task automatic check_response();
        rdrs_packet_t  got;
        logic [DW-1:0] exp_data;
        int            age;
        got = proc_rdrs;
        if (!last_en) begin
            // stalled edge so the port must hold
            assert (got == last_rdrs) else begin
                $display("** Error at time %0t: proc_rdrs changed while clk_en was low",
                         $time);
                stall_errors++;
            end
        end else begin
            foreach (age_q[i]) begin
                age_q[i]++;
            end
            if (got.rd_data_valid) begin
                assert (exp_q.size() > 0) else begin
                    $display("read response arrived at time %0t with no read outstanding",
                             $time);
                    order_errors++;
                end
                if (exp_q.size() > 0) begin
                    exp_data = exp_q.pop_front();
                    age      = age_q.pop_front();
                    assert (got.rd_data == exp_data) else begin
                        $display("** Error at time %0t: read data %h, expected %h",
                                 $time, got.rd_data, exp_data);
                        data_errors++;
                    end
                    assert (age == LATENCY) else begin
                        $display("** Error at time %0t: read latency %0d, expected %0d",
                                 $time, age, LATENCY);
                        latency_errors++;
                    end
                end
            end else if (age_q.size() > 0) begin
                // oldest read overdue means it was lost
                assert (age_q[0] < LATENCY) else begin
                    $display("read response missing at time %0t, the read was dropped",
                             $time);
                    order_errors++;
                    void'(exp_q.pop_front());
                    void'(age_q.pop_front());
                end
            end
        end
        last_rdrs = got;
    endtask

    // drive one beat and update the model only when enabled
    task automatic drive_cycle(input logic en, input logic we, input logic [AW-1:0] waddr,
                               input logic [DW-1:0] wdata, input logic re,
                               input logic [AW-1:0] raddr);
        @(negedge clk);
        check_response();
        clk_en            = en;
        proc_wr.wr_en     = we;
        proc_wr.wr_addr   = waddr;
        proc_wr.wr_data   = wdata;
        proc_rdrq.rd_en   = re;
        proc_rdrq.rd_addr = raddr;
        if (en) begin
            // read sees the old word when a write shares its beat
            if (re) begin
                exp_q.push_back(ref_mem[raddr]);
                age_q.push_back(0);
            end
            if (we) begin
                ref_mem[waddr] = wdata;
            end
        end
        last_en = en;
    endtask

    task automatic send_idle();
        drive_cycle(1'b1, 1'b0, '0, '0, 1'b0, '0);
    endtask

    // random write and read where reads often chase the last write
    task automatic random_beat(input logic en);
        logic          we;
        logic          re;
        logic [AW-1:0] waddr;
        logic [AW-1:0] raddr;
        we    = 1'($urandom_range(0, 1));
        re    = ($urandom_range(0, 3) != 0);
        waddr = AW'($urandom_range(0, NUM_ADDRS - 1));
        if ($urandom_range(0, 1) == 1) begin
            raddr = last_waddr;
        end else begin
            raddr = AW'($urandom_range(0, NUM_ADDRS - 1));
        end
        drive_cycle(en, we, waddr, $urandom(), re, raddr);
        if (en && we) begin
            last_waddr = waddr;
        end
    endtask

    initial begin : main
        logic [AW-1:0] addr;
        int            drain;
        int            total;
        clk            = 1'b0;
        reset          = 1'b1;
        clk_en         = 1'b0;
        proc_wr        = '0;
        proc_rdrq      = '0;
        last_en        = 1'b1;
        last_rdrs      = '0;
        last_waddr     = '0;
        data_errors    = 0;
        latency_errors = 0;
        order_errors   = 0;
        stall_errors   = 0;
        for (int i = 0; i < NUM_ADDRS; i++) begin
            ref_mem[i] = '0;
        end
        void'($urandom(57013));

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset  = 1'b0;
        clk_en = 1'b1;

        // quiet port after reset
        repeat (IDLE_CYCLES) send_idle();

        // unwritten words of every tile read back as zero
        for (int a = 0; a < NUM_ADDRS; a++) begin
            drive_cycle(1'b1, 1'b0, '0, '0, 1'b1, AW'(a));
        end

        // writes spread over all tiles and then read back
        for (int i = 0; i < NUM_PAIRS; i++) begin
            addr = AW'((i % NUM_TILES) * (2 ** BW) + $urandom_range(0, 2 ** BW - 1));
            wr_addrs.push_back(addr);
            drive_cycle(1'b1, 1'b1, addr, $urandom(), 1'b0, '0);
        end
        foreach (wr_addrs[i]) begin
            drive_cycle(1'b1, 1'b0, '0, '0, 1'b1, wr_addrs[i]);
        end

        // back to back mixed traffic
        repeat (MIX_CYCLES) random_beat(1'b1);

        // same traffic with a stall on about one in three edges
        repeat (STALL_CYCLES) random_beat($urandom_range(0, 2) != 0);

        // drain outstanding reads
        drain = 0;
        while (exp_q.size() > 0 && drain < 4 * NUM_TILES) begin
            send_idle();
            drain++;
        end
        repeat (4) send_idle();

        total = data_errors + latency_errors + order_errors + stall_errors;
        $display("error counts: data %0d, latency %0d, order %0d, stall %0d",
                 data_errors, latency_errors, order_errors, stall_errors);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // bound on run time
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired at time %0t, the run did not complete", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
rtl/glb_pkg.sv
rtl/glb_proc_router.sv
rtl/glb_bank.sv
rtl/glb_tile.sv
rtl/glb_top.sv
sim/glb_props.sv
sim/glb_tb.sv
